// File: build.f
design/slot_dma_pkg.sv
design/desc_fifo.sv
design/slot_cfg_apb.sv
design/slot_recycler.sv
design/rx_desc_issuer.sv
design/trigger_writer.sv
design/slot_dma_top.sv
testbench/slot_dma_sva.sv
testbench/slot_dma_tb.sv

// File: Bender.yml
package:
  name: slot_dma

sources:
  - design/slot_dma_pkg.sv
  - design/desc_fifo.sv
  - design/slot_cfg_apb.sv
  - design/slot_recycler.sv
  - design/rx_desc_issuer.sv
  - design/trigger_writer.sv
  - design/slot_dma_top.sv
  - target: test
    files:
      - testbench/slot_dma_sva.sv
      - testbench/slot_dma_tb.sv

// File: testbench/slot_dma_tb.sv
`default_nettype none
`timescale 1ns/10ps

module slot_dma_tb;

  import slot_dma_pkg::*;

  localparam int   SLOT_DEPTH    = 8;
  localparam int   TRIG_DEPTH    = 16;
  localparam len_t RESET_MAX_LEN = 16'd1518;
  localparam int   NUM_TESTS     = 8;
  localparam int   WAIT_LIMIT    = 60;

  logic        clk, rst, psel, penable, pwrite, pready, pslverr;
  logic [7:0]  paddr;
  logic [31:0] pwdata, prdata;
  logic        free_valid, inject_valid, inject_ready;
  core_no_t    free_core;
  slot_no_t    free_slot;
  slot_desc_t  inject_slot;
  logic        pkt_arrived, pkt_delivered, rx_desc_valid, rx_desc_ready;
  len_t        pkt_delivered_len, rx_desc_len;
  dma_addr_t   rx_desc_addr, trig_addr;
  logic        trig_valid, trig_ready, resp_valid, resp_err;
  trig_data_t  trig_data;

  int          errors;
  int          checks;
  int          spare_credit;
  logic [7:0]  base_tab [SLOT_COUNT];
  len_t        max_len_cfg;
  logic [31:0] word;
  logic        err;
  string       name_tab [NUM_TESTS];
  core_no_t    core_tab [NUM_TESTS];
  slot_no_t    slot_tab [NUM_TESTS];
  logic [7:0]  drop_tab [NUM_TESTS];
  len_t        len_tab [NUM_TESTS];
  bit          drop_exp_tab [NUM_TESTS];
  bit          bad_tab [NUM_TESTS];
  core_no_t    adv_core [3] = '{3'd1, 3'd2, 3'd5};
  slot_no_t    adv_slot [3] = '{4'd9, 4'd10, 4'd11};
  len_t        adv_len [3] = '{16'd100, 16'd200, 16'd300};

  slot_dma_top #(
    .SLOT_FIFO_DEPTH(SLOT_DEPTH),
    .TRIG_FIFO_DEPTH(TRIG_DEPTH),
    .DEFAULT_MAX_LEN(RESET_MAX_LEN)
  ) dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (NUM_TESTS * 200) @(posedge clk);
    $display("Watchdog timeout: the run did not finish in time");
    $display("Test failures found");
    $finish;
  end

  task automatic check_addr(input string name, input dma_addr_t exp, input dma_addr_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_len(input string name, input len_t exp, input len_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flags(input string name, input err_flags_t exp, input err_flags_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input trig_data_t exp, input trig_data_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  function automatic dma_addr_t exp_rx_addr(input core_no_t core, input slot_no_t slot);
    dma_addr_t a;
    a = '0;
    a[23:21] = core;
    a[15:8] = base_tab[slot];
    return a;
  endfunction

  function automatic dma_addr_t exp_trig_addr(input core_no_t core, input slot_no_t slot);
    dma_addr_t a;
    a = '0;
    a[23:21] = core;
    a[8] = 1'b1;
    a[6:3] = slot;
    return a;
  endfunction

  function automatic trig_data_t exp_trig_data(input slot_no_t slot, input len_t len);
    trig_data_t d;
    d = '0;
    d[39:32] = base_tab[slot];
    d[27:24] = slot;
    d[15:0] = len;
    return d;
  endfunction

  task automatic add_test(input int i, input string name, input core_no_t core,
                          input slot_no_t slot, input logic [7:0] drop, input len_t len,
                          input bit drop_exp, input bit bad);
    name_tab[i] = name;
    core_tab[i] = core;
    slot_tab[i] = slot;
    drop_tab[i] = drop;
    len_tab[i] = len;
    drop_exp_tab[i] = drop_exp;
    bad_tab[i] = bad;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    psel = 1'b1;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic slverr);
    @(negedge clk);
    psel = 1'b1;
    pwrite = 1'b0;
    paddr = addr;
    @(negedge clk);
    penable = 1'b1;
    #1;
    data = prdata;
    slverr = pslverr;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic free_pulse(input core_no_t core, input slot_no_t slot);
    @(negedge clk);
    free_valid = 1'b1;
    free_core = core;
    free_slot = slot;
    @(negedge clk);
    free_valid = 1'b0;
  endtask

  task automatic arrive();
    @(negedge clk);
    pkt_arrived = 1'b1;
    @(negedge clk);
    pkt_arrived = 1'b0;
  endtask

  task automatic deliver(input len_t len);
    @(negedge clk);
    pkt_delivered = 1'b1;
    pkt_delivered_len = len;
    @(negedge clk);
    pkt_delivered = 1'b0;
  endtask

  // Nothing may leave the DUT for n cycles
  task automatic expect_quiet(input string name, input int n);
    bit seen;
    seen = 1'b0;
    repeat (n) begin
      @(negedge clk);
      #1;
      if ((rx_desc_valid || trig_valid) && !seen) begin
        seen = 1'b1;
        errors++;
        $display("%s: descriptor or trigger appeared when none was expected", name);
      end
    end
  endtask

  // DMA engine model with random acceptance
  task automatic recv_desc(input string name, input dma_addr_t exp_addr, input len_t exp_len);
    int n;
    bit got;
    n = 0;
    got = 1'b0;
    while (!got && n < WAIT_LIMIT) begin
      @(negedge clk);
      rx_desc_ready = (n >= 20) ? 1'b1 : 1'($urandom % 2);
      #1;
      if (rx_desc_valid && rx_desc_ready) begin
        got = 1'b1;
        check_addr({name, " rx addr"}, exp_addr, rx_desc_addr);
        check_len({name, " rx len"}, exp_len, rx_desc_len);
      end
      n++;
    end
    @(negedge clk);
    rx_desc_ready = 1'b0;
    if (!got) begin
      errors++;
      $display("%s: no receive descriptor appeared", name);
    end
  endtask

  // Write target model, answers each beat with one response
  task automatic recv_trig(input string name, input dma_addr_t exp_addr,
                           input trig_data_t exp_data, input bit bad);
    int n;
    bit got;
    n = 0;
    got = 1'b0;
    while (!got && n < WAIT_LIMIT) begin
      @(negedge clk);
      trig_ready = (n >= 20) ? 1'b1 : 1'($urandom % 2);
      #1;
      if (trig_valid && trig_ready) begin
        got = 1'b1;
        check_addr({name, " trig addr"}, exp_addr, trig_addr);
        check_data({name, " trig data"}, exp_data, trig_data);
      end
      n++;
    end
    @(negedge clk);
    trig_ready = 1'b0;
    resp_valid = got;
    resp_err = bad;
    @(negedge clk);
    resp_valid = 1'b0;
    resp_err = 1'b0;
    if (!got) begin
      errors++;
      $display("%s: no trigger write appeared", name);
    end
  endtask

  task automatic run_entry(input int i);
    apb_write(REG_DROP, {24'h0, drop_tab[i]});
    free_pulse(core_tab[i], slot_tab[i]);
    if (drop_exp_tab[i]) begin
      // A dropped slot leaves the arrival behind as credit
      arrive();
      expect_quiet(name_tab[i], 12);
      spare_credit++;
    end else begin
      if (spare_credit > 0) begin
        spare_credit--;
      end else begin
        // Held until the packet arrives
        expect_quiet(name_tab[i], 6);
        arrive();
      end
      recv_desc(name_tab[i], exp_rx_addr(core_tab[i], slot_tab[i]), max_len_cfg);
      deliver(len_tab[i]);
      recv_trig(name_tab[i], exp_trig_addr(core_tab[i], slot_tab[i]),
                exp_trig_data(slot_tab[i], len_tab[i]), bad_tab[i]);
      if (bad_tab[i]) begin
        repeat (3) @(negedge clk);
        apb_read(REG_STATUS, word, err);
        check_flags({name_tab[i], " status set"}, err_flags_t'(3'b100), word[2:0]);
        apb_write(REG_STATUS, 32'h4);
        apb_read(REG_STATUS, word, err);
        check_flags({name_tab[i], " status clear"}, err_flags_t'(3'b000), word[2:0]);
      end
    end
  endtask

  initial begin
    void'($urandom(84));
    errors = 0;
    checks = 0;
    spare_credit = 0;
    rst = 1'b1;
    {psel, penable, pwrite, paddr, pwdata} = '0;
    {free_valid, free_core, free_slot, inject_valid, inject_slot} = '0;
    {pkt_arrived, pkt_delivered, pkt_delivered_len} = '0;
    {rx_desc_ready, trig_ready, resp_valid, resp_err} = '0;
    add_test(0, "core0_slot0", 3'd0, 4'd0, 8'h00, 16'd64, 1'b0, 1'b0);
    add_test(1, "core7_slot15", 3'd7, 4'd15, 8'h00, 16'd1518, 1'b0, 1'b0);
    add_test(2, "core2_dropped", 3'd2, 4'd3, 8'h04, 16'd0, 1'b1, 1'b0);
    add_test(3, "core3_bad_resp", 3'd3, 4'd5, 8'h04, 16'd300, 1'b0, 1'b1);
    add_test(4, "core5_slot8", 3'd5, 4'd8, 8'h41, 16'd9000, 1'b0, 1'b0);
    add_test(5, "core6_dropped", 3'd6, 4'd1, 8'h40, 16'd0, 1'b1, 1'b0);
    add_test(6, "core1_slot12", 3'd1, 4'd12, 8'h80, 16'd1, 1'b0, 1'b0);
    add_test(7, "core4_slot7", 3'd4, 4'd7, 8'he0, 16'hffff, 1'b0, 1'b0);
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Register access
    apb_read(REG_MAXLEN, word, err);
    check_len("maxlen reset", RESET_MAX_LEN, word[15:0]);
    max_len_cfg = 16'd2000;
    apb_write(REG_MAXLEN, {16'h0, max_len_cfg});
    apb_read(REG_MAXLEN, word, err);
    check_len("maxlen readback", max_len_cfg, word[15:0]);
    for (int n = 0; n < SLOT_COUNT; n++) begin
      base_tab[n] = 8'(n * 37 + 11) ^ 8'h5a;
      apb_write(8'(REG_SLOT_BASE + 4 * n), {24'h0, base_tab[n]});
    end
    for (int n = 0; n < SLOT_COUNT; n++) begin
      apb_read(8'(REG_SLOT_BASE + 4 * n), word, err);
      check_len($sformatf("slot base %0d", n), {8'h0, base_tab[n]}, word[15:0]);
    end
    apb_write(REG_DROP, 32'h81);
    apb_read(REG_DROP, word, err);
    check_len("drop readback", 16'h81, word[15:0]);
    check_bit("mapped pslverr", 1'b0, err);
    apb_read(8'h20, word, err);
    check_bit("unmapped pslverr", 1'b1, err);

    for (int i = 0; i < NUM_TESTS; i++) begin
      run_entry(i);
    end

    // Arrivals ahead of the frees
    apb_write(REG_DROP, 32'h0);
    repeat (3) arrive();
    for (int k = 0; k < 3; k++) begin
      free_pulse(adv_core[k], adv_slot[k]);
    end
    for (int k = 0; k < 3; k++) begin
      recv_desc($sformatf("advance_%0d", k), exp_rx_addr(adv_core[k], adv_slot[k]),
                max_len_cfg);
    end
    for (int k = 0; k < 3; k++) begin
      deliver(adv_len[k]);
      recv_trig($sformatf("advance_%0d", k), exp_trig_addr(adv_core[k], adv_slot[k]),
                exp_trig_data(adv_slot[k], adv_len[k]), 1'b0);
    end

    // Inject loses to a free in the same cycle
    apb_write(REG_DROP, 32'hff);
    @(negedge clk);
    free_valid = 1'b1;
    free_core = 3'd3;
    free_slot = 4'd4;
    inject_valid = 1'b1;
    inject_slot.core = 3'd5;
    inject_slot.slot = 4'd6;
    #1;
    check_bit("inject with free", 1'b0, inject_ready);
    @(negedge clk);
    free_valid = 1'b0;
    #1;
    check_bit("inject alone", 1'b1, inject_ready);
    @(negedge clk);
    inject_valid = 1'b0;
    // Arrivals would release either slot had it not been dropped
    repeat (2) arrive();
    expect_quiet("inject_dropped", 10);

    // Slot queue overflow with the engine stalled
    apb_write(REG_DROP, 32'h0);
    for (int k = 0; k < SLOT_DEPTH + 3; k++) begin
      @(negedge clk);
      free_valid = 1'b1;
      free_core = 3'(k);
      free_slot = 4'(k);
    end
    @(negedge clk);
    free_valid = 1'b0;
    repeat (3) @(negedge clk);
    apb_read(REG_STATUS, word, err);
    check_flags("slot overflow set", err_flags_t'(3'b001), word[2:0]);
    apb_write(REG_STATUS, 32'h1);
    apb_read(REG_STATUS, word, err);
    check_flags("slot overflow clear", err_flags_t'(3'b000), word[2:0]);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/slot_dma_sva.sv
`default_nettype none
`timescale 1ns/10ps

module slot_dma_sva (
  input wire                           clk,
  input wire                           rst,
  input wire                           rx_desc_valid,
  input wire                           rx_desc_ready,
  input wire slot_dma_pkg::dma_addr_t  rx_desc_addr,
  input wire                           trig_valid,
  input wire                           trig_ready,
  input wire slot_dma_pkg::dma_addr_t  trig_addr,
  input wire slot_dma_pkg::trig_data_t trig_data,
  input wire                           inject_ready,
  input wire                           pready
);

  // Valid and payload hold until the handshake
  rx_hold: assert property (@(posedge clk) disable iff (rst)
    rx_desc_valid && !rx_desc_ready |=> rx_desc_valid && $stable(rx_desc_addr))
    else $error("rx_desc_valid dropped or changed before rx_desc_ready");

  trig_hold: assert property (@(posedge clk) disable iff (rst)
    trig_valid && !trig_ready |=> trig_valid && $stable(trig_addr) && $stable(trig_data))
    else $error("trig_valid dropped or changed before trig_ready");

  reset_quiet: assert property (@(posedge clk)
    rst |=> !rx_desc_valid && !trig_valid && !inject_ready)
    else $error("valid output high during reset");

  no_wait: assert property (@(posedge clk) pready)
    else $error("pready low");

endmodule

bind slot_dma_top slot_dma_sva u_sva (.*);

`default_nettype wire

// File: design/slot_dma_top.sv
`default_nettype none
`timescale 1ns/10ps

module slot_dma_top #(
  parameter int                 SLOT_FIFO_DEPTH = 8,
  parameter int                 TRIG_FIFO_DEPTH = 16,
  parameter slot_dma_pkg::len_t DEFAULT_MAX_LEN = 16'd1518
) (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire                                  psel,
  input  wire                                  penable,
  input  wire                                  pwrite,
  input  wire  [slot_dma_pkg::APB_ADDR_W-1:0]  paddr,
  input  wire  [slot_dma_pkg::APB_DATA_W-1:0]  pwdata,
  output logic [slot_dma_pkg::APB_DATA_W-1:0]  prdata,
  output logic                                 pready,
  output logic                                 pslverr,
  input  wire                                  free_valid,
  input  wire  slot_dma_pkg::core_no_t         free_core,
  input  wire  slot_dma_pkg::slot_no_t         free_slot,
  input  wire                                  inject_valid,
  input  wire  slot_dma_pkg::slot_desc_t       inject_slot,
  output logic                                 inject_ready,
  input  wire                                  pkt_arrived,
  input  wire                                  pkt_delivered,
  input  wire  slot_dma_pkg::len_t             pkt_delivered_len,
  output logic                                 rx_desc_valid,
  input  wire                                  rx_desc_ready,
  output slot_dma_pkg::dma_addr_t              rx_desc_addr,
  output slot_dma_pkg::len_t                   rx_desc_len,
  output logic                                 trig_valid,
  input  wire                                  trig_ready,
  output slot_dma_pkg::dma_addr_t              trig_addr,
  output slot_dma_pkg::trig_data_t             trig_data,
  input  wire                                  resp_valid,
  input  wire                                  resp_err
);

  import slot_dma_pkg::*;

  slot_desc_t             slot_q_data;
  slot_desc_t             iss_in_data;
  trig_entry_t            trig_push_data;
  trig_entry_t            trig_in_data;
  err_flags_t             err_set;
  logic [CORE_COUNT-1:0]  drop_list;
  len_t                   max_len;
  slot_no_t               slot_rd_no;
  logic [SLOT_BASE_W-1:0] slot_rd_base;
  logic                   slot_q_valid;
  logic                   slot_q_ready;
  logic                   iss_in_valid;
  logic                   iss_in_ready;
  logic                   trig_push_valid;
  logic                   trig_push_ready;
  logic                   trig_in_valid;
  logic                   trig_in_ready;
  logic                   slot_overflow;
  logic                   trig_overflow;
  logic                   resp_fault;

  assign err_set = '{resp_err: resp_fault, trig_ovf: trig_overflow, slot_ovf: slot_overflow};

  slot_cfg_apb #(
    .DEFAULT_MAX_LEN(DEFAULT_MAX_LEN)
  ) u_cfg (
    .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .err_set(err_set), .drop_list(drop_list), .max_len(max_len),
    .slot_rd_no(slot_rd_no), .slot_rd_base(slot_rd_base)
  );

  slot_recycler u_recycler (
    .clk(clk), .rst(rst), .free_valid(free_valid), .free_core(free_core),
    .free_slot(free_slot), .inject_valid(inject_valid), .inject_slot(inject_slot),
    .inject_ready(inject_ready), .q_valid(slot_q_valid), .q_ready(slot_q_ready),
    .q_data(slot_q_data), .overflow(slot_overflow)
  );

  desc_fifo #(
    .T(slot_desc_t),
    .DEPTH(SLOT_FIFO_DEPTH)
  ) u_slot_fifo (
    .clk(clk), .rst(rst), .in_valid(slot_q_valid), .in_ready(slot_q_ready),
    .in_data(slot_q_data), .out_valid(iss_in_valid), .out_ready(iss_in_ready),
    .out_data(iss_in_data)
  );

  rx_desc_issuer u_issuer (
    .clk(clk), .rst(rst), .in_valid(iss_in_valid), .in_data(iss_in_data),
    .in_ready(iss_in_ready), .drop_list(drop_list), .max_len(max_len),
    .slot_rd_no(slot_rd_no), .slot_rd_base(slot_rd_base), .pkt_arrived(pkt_arrived),
    .rx_desc_valid(rx_desc_valid), .rx_desc_addr(rx_desc_addr),
    .rx_desc_len(rx_desc_len), .rx_desc_ready(rx_desc_ready),
    .trig_push_valid(trig_push_valid), .trig_push_data(trig_push_data),
    .trig_push_ready(trig_push_ready), .trig_overflow(trig_overflow)
  );

  desc_fifo #(
    .T(trig_entry_t),
    .DEPTH(TRIG_FIFO_DEPTH)
  ) u_trig_fifo (
    .clk(clk), .rst(rst), .in_valid(trig_push_valid), .in_ready(trig_push_ready),
    .in_data(trig_push_data), .out_valid(trig_in_valid), .out_ready(trig_in_ready),
    .out_data(trig_in_data)
  );

  trigger_writer u_trig_writer (
    .clk(clk), .rst(rst), .in_valid(trig_in_valid), .in_data(trig_in_data),
    .in_ready(trig_in_ready), .pkt_delivered(pkt_delivered),
    .pkt_delivered_len(pkt_delivered_len), .trig_valid(trig_valid),
    .trig_addr(trig_addr), .trig_data(trig_data), .trig_ready(trig_ready),
    .resp_valid(resp_valid), .resp_err(resp_err), .resp_fault(resp_fault)
  );

endmodule

`default_nettype wire

// File: design/trigger_writer.sv
`default_nettype none
`timescale 1ns/10ps

module trigger_writer (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               in_valid,
  input  wire  slot_dma_pkg::trig_entry_t   in_data,
  output logic                              in_ready,
  input  wire                               pkt_delivered,
  input  wire  slot_dma_pkg::len_t          pkt_delivered_len,
  output logic                              trig_valid,
  output slot_dma_pkg::dma_addr_t           trig_addr,
  output slot_dma_pkg::trig_data_t          trig_data,
  input  wire                               trig_ready,
  input  wire                               resp_valid,
  input  wire                               resp_err,
  output logic                              resp_fault
);

  import slot_dma_pkg::*;

  logic [CREDIT_W-1:0] credit;
  len_t                last_len;
  len_t                beat_len;
  logic                issue;

  // Delivery pulses ahead of their entry are kept as credit
  assign issue    = in_valid && !trig_valid && ((credit != '0) || pkt_delivered);
  assign in_ready = issue;
  assign beat_len = pkt_delivered ? pkt_delivered_len : last_len;

  always_ff @(posedge clk) begin
    if (pkt_delivered) begin
      last_len <= pkt_delivered_len;
    end
    if (issue) begin
      // Core mailbox, bit 8 marks the trigger region
      trig_addr <= {in_data.core, 12'h000, 1'b1, 1'b0, in_data.slot, 3'b000};
      trig_data <= {24'h000000, in_data.base, {(8 - SLOT_NO_W){1'b0}}, in_data.slot,
                    8'h00, beat_len};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      trig_valid <= 1'b0;
      credit     <= '0;
      resp_fault <= 1'b0;
    end else begin
      if (issue) begin
        trig_valid <= 1'b1;
      end else if (trig_valid && trig_ready) begin
        trig_valid <= 1'b0;
      end
      credit     <= credit + CREDIT_W'(pkt_delivered) - CREDIT_W'(issue);
      resp_fault <= resp_valid && resp_err;
    end
  end

endmodule

`default_nettype wire

// File: design/rx_desc_issuer.sv
`default_nettype none
`timescale 1ns/10ps

module rx_desc_issuer (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire                                   in_valid,
  input  wire  slot_dma_pkg::slot_desc_t        in_data,
  output logic                                  in_ready,
  input  wire  [slot_dma_pkg::CORE_COUNT-1:0]   drop_list,
  input  wire  slot_dma_pkg::len_t              max_len,
  output slot_dma_pkg::slot_no_t                slot_rd_no,
  input  wire  [slot_dma_pkg::SLOT_BASE_W-1:0]  slot_rd_base,
  input  wire                                   pkt_arrived,
  output logic                                  rx_desc_valid,
  output slot_dma_pkg::dma_addr_t               rx_desc_addr,
  output slot_dma_pkg::len_t                    rx_desc_len,
  input  wire                                   rx_desc_ready,
  output logic                                  trig_push_valid,
  output slot_dma_pkg::trig_entry_t             trig_push_data,
  input  wire                                   trig_push_ready,
  output logic                                  trig_overflow
);

  import slot_dma_pkg::*;

  localparam int ADDR_GAP = ADDR_W - CORE_NO_W - SLOT_BASE_W - 8;

  slot_desc_t          hold_desc;
  logic                hold_valid;
  logic                hold_drop;
  logic                armed;
  logic                grant;
  logic                accept;
  logic                done;
  logic                pop;
  logic [CREDIT_W-1:0] credit;

  // One descriptor in flight
  assign in_ready = !hold_valid;
  assign pop      = in_valid && in_ready;
  assign done     = hold_valid && (hold_drop || accept);

  // Keep the table read on the held slot until it leaves
  assign slot_rd_no = hold_valid ? hold_desc.slot : in_data.slot;

  // Grant takes one packet credit, armed keeps valid up until ready
  assign grant         = hold_valid && !hold_drop && !armed && ((credit != '0) || pkt_arrived);
  assign rx_desc_valid = grant || armed;
  assign accept        = rx_desc_valid && rx_desc_ready;

  assign rx_desc_addr = {hold_desc.core, {ADDR_GAP{1'b0}}, slot_rd_base, 8'h00};
  assign rx_desc_len  = max_len;

  assign trig_push_valid     = accept;
  assign trig_push_data.core = hold_desc.core;
  assign trig_push_data.slot = hold_desc.slot;
  assign trig_push_data.base = slot_rd_base;

  always_ff @(posedge clk) begin
    if (pop) begin
      hold_desc <= in_data;
      hold_drop <= drop_list[in_data.core];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hold_valid    <= 1'b0;
      armed         <= 1'b0;
      credit        <= '0;
      trig_overflow <= 1'b0;
    end else begin
      if (pop) begin
        hold_valid <= 1'b1;
      end else if (done) begin
        hold_valid <= 1'b0;
      end
      if (accept) begin
        armed <= 1'b0;
      end else if (grant) begin
        armed <= 1'b1;
      end
      credit        <= credit + CREDIT_W'(pkt_arrived) - CREDIT_W'(grant);
      trig_overflow <= accept && !trig_push_ready;
    end
  end

endmodule

`default_nettype wire

// File: design/slot_recycler.sv
`default_nettype none
`timescale 1ns/10ps

module slot_recycler (
  input  wire                             clk,
  input  wire                             rst,
  input  wire                             free_valid,
  input  wire  slot_dma_pkg::core_no_t    free_core,
  input  wire  slot_dma_pkg::slot_no_t    free_slot,
  input  wire                             inject_valid,
  input  wire  slot_dma_pkg::slot_desc_t  inject_slot,
  output logic                            inject_ready,
  output logic                            q_valid,
  input  wire                             q_ready,
  output slot_dma_pkg::slot_desc_t        q_data,
  output logic                            overflow
);

  logic free_lost;

  // Freed slots have no back-pressure and always win
  assign q_valid      = free_valid || inject_valid;
  assign inject_ready = !free_valid && q_ready;
  assign free_lost    = free_valid && !q_ready;

  always_comb begin
    if (free_valid) begin
      q_data.core = free_core;
      q_data.slot = free_slot;
    end else begin
      q_data = inject_slot;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      overflow <= 1'b0;
    end else begin
      overflow <= free_lost;
    end
  end

endmodule

`default_nettype wire

// File: design/slot_cfg_apb.sv
`default_nettype none
`timescale 1ns/10ps

module slot_cfg_apb #(
  parameter slot_dma_pkg::len_t DEFAULT_MAX_LEN = 16'd1518
) (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire                                   psel,
  input  wire                                   penable,
  input  wire                                   pwrite,
  input  wire  [slot_dma_pkg::APB_ADDR_W-1:0]   paddr,
  input  wire  [slot_dma_pkg::APB_DATA_W-1:0]   pwdata,
  output logic [slot_dma_pkg::APB_DATA_W-1:0]   prdata,
  output logic                                  pready,
  output logic                                  pslverr,
  input  wire  slot_dma_pkg::err_flags_t        err_set,
  output logic [slot_dma_pkg::CORE_COUNT-1:0]   drop_list,
  output slot_dma_pkg::len_t                    max_len,
  input  wire  slot_dma_pkg::slot_no_t          slot_rd_no,
  output logic [slot_dma_pkg::SLOT_BASE_W-1:0]  slot_rd_base
);

  import slot_dma_pkg::*;

  localparam int ERR_W     = $bits(err_flags_t);
  localparam int SLOT_LAST = REG_SLOT_BASE + 4 * (SLOT_COUNT - 1);

  logic [SLOT_BASE_W-1:0] slot_mem [SLOT_COUNT];
  err_flags_t             err_q;
  logic [ERR_W-1:0]       err_clr;
  slot_no_t               apb_slot;
  logic                   is_drop;
  logic                   is_maxlen;
  logic                   is_status;
  logic                   is_slot;
  logic                   access;
  logic                   wr_en;

  assign access    = psel && penable;
  assign is_drop   = (paddr == REG_DROP);
  assign is_maxlen = (paddr == REG_MAXLEN);
  assign is_status = (paddr == REG_STATUS);
  assign is_slot   = (paddr >= REG_SLOT_BASE) && (int'(paddr) <= SLOT_LAST) &&
                     (paddr[1:0] == 2'b00);
  assign apb_slot  = paddr[2 +: SLOT_NO_W];

  // No wait states
  assign pready  = 1'b1;
  assign pslverr = access && !(is_drop || is_maxlen || is_status || is_slot);
  assign wr_en   = access && pwrite && !pslverr;
  assign err_clr = (wr_en && is_status) ? pwdata[ERR_W-1:0] : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      drop_list <= '0;
      max_len   <= DEFAULT_MAX_LEN;
      err_q     <= '0;
    end else begin
      if (wr_en && is_drop) begin
        drop_list <= pwdata[CORE_COUNT-1:0];
      end
      if (wr_en && is_maxlen) begin
        max_len <= pwdata[LEN_W-1:0];
      end
      // A new error beats a clear in the same cycle
      err_q <= (err_q & ~err_clr) | err_set;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && is_slot) begin
      slot_mem[apb_slot] <= pwdata[SLOT_BASE_W-1:0];
    end
    slot_rd_base <= slot_mem[slot_rd_no];
  end

  always_comb begin
    prdata = '0;
    if (is_drop) begin
      prdata[CORE_COUNT-1:0] = drop_list;
    end else if (is_maxlen) begin
      prdata[LEN_W-1:0] = max_len;
    end else if (is_status) begin
      prdata[ERR_W-1:0] = err_q;
    end else if (is_slot) begin
      prdata[SLOT_BASE_W-1:0] = slot_mem[apb_slot];
    end
  end

endmodule

`default_nettype wire

// File: design/desc_fifo.sv
`default_nettype none
`timescale 1ns/10ps

module desc_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input  wire  clk,
  input  wire  rst,
  input  wire  in_valid,
  output logic in_ready,
  input  wire  T in_data,
  output logic out_valid,
  input  wire  out_ready,
  output T     out_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             push;
  logic             pop;

  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + 1'b1;
    end else if (pop && !push) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Ready is registered, so it stays low through reset
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count    <= count_next;
      in_ready <= (count_next != CNT_W'(DEPTH));
    end
  end

endmodule

`default_nettype wire

// File: design/slot_dma_pkg.sv
`default_nettype none

package slot_dma_pkg;

  localparam int CORE_NO_W   = 3;
  localparam int SLOT_NO_W   = 4;
  localparam int CORE_COUNT  = 8;
  localparam int SLOT_COUNT  = 16;
  localparam int ADDR_W      = 24;
  localparam int LEN_W       = 16;
  localparam int SLOT_BASE_W = 8;
  localparam int CREDIT_W    = 10;
  localparam int TRIG_DATA_W = 64;
  localparam int APB_ADDR_W  = 8;
  localparam int APB_DATA_W  = 32;

  typedef logic [CORE_NO_W-1:0]   core_no_t;
  typedef logic [SLOT_NO_W-1:0]   slot_no_t;
  typedef logic [ADDR_W-1:0]      dma_addr_t;
  typedef logic [LEN_W-1:0]       len_t;
  typedef logic [TRIG_DATA_W-1:0] trig_data_t;

  typedef struct packed {
    core_no_t core;
    slot_no_t slot;
  } slot_desc_t;

  typedef struct packed {
    core_no_t               core;
    slot_no_t               slot;
    logic [SLOT_BASE_W-1:0] base;
  } trig_entry_t;

  // Status register bits 2..0
  typedef struct packed {
    logic resp_err;
    logic trig_ovf;
    logic slot_ovf;
  } err_flags_t;

  localparam logic [APB_ADDR_W-1:0] REG_DROP      = 8'h00;
  localparam logic [APB_ADDR_W-1:0] REG_MAXLEN    = 8'h04;
  localparam logic [APB_ADDR_W-1:0] REG_STATUS    = 8'h08;
  localparam logic [APB_ADDR_W-1:0] REG_SLOT_BASE = 8'h40;

endpackage

`default_nettype wire
